/* verilog/cache_pkg.sv */
// ######################################################################
// data cache shared types
// ######################################################################

package cache_pkg;

    // cache geometry
    localparam int WAYS            = 2;
    localparam int SETS            = 2;
    localparam int WORDS_PER_BLOCK = 2;
    localparam int TAG_BITS        = 28;

    // backing memory, word addressed by bits 9:2
    localparam int MEM_WORDS    = 256;
    localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY  = 3;
    localparam int LAT_BITS     = $clog2(MEM_LATENCY + 1);

    typedef logic [31:0] data_word_t;

    typedef data_word_t [WORDS_PER_BLOCK-1:0] block_data_t;

    // tag / index / word offset / byte within word
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [0:0]          index;
        logic [0:0]          offset;
        logic [1:0]          byte_sel;
    } addr_fields_t;

    // raw on the memory side, fields on the cache side
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic                lru;
        logic [TAG_BITS-1:0] tag;
        logic                valid;
        logic                dirty;
        block_data_t         data;
    } block_t;

    typedef block_t [WAYS-1:0] cache_set_t;

    typedef struct packed {
        logic        we;
        cache_addr_u addr;
        logic [3:0]  byte_mask;
        data_word_t  write_word;
    } cpu_req_t;

    // write port bundle towards memory
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        block_data_t block;
    } mem_wb_t;

endpackage

/* verilog/cache_lookup.sv */
// ######################################################################
// set tag compare and victim select
// ######################################################################

`timescale 1ns/1ps

module cache_lookup (
    input  cache_pkg::cache_set_t           set_ways,
    input  logic [cache_pkg::TAG_BITS-1:0]  tag,
    output logic                            hit,
    output logic                            hit_way,
    output logic                            victim_way
);
    import cache_pkg::*;

    logic [WAYS-1:0] way_match;

    // per-way match, invalid ways never match
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_match[w] = set_ways[w].valid && (set_ways[w].tag == tag);
        end
    end

    assign hit = |way_match;

    // encode the matching way
    always_comb begin
        hit_way = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_match[w]) begin
                hit_way = 1'(w);
            end
        end
    end

    // lru bit set means least recently used
    always_comb begin
        victim_way = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (set_ways[w].lru) begin
                victim_way = 1'(w);
            end
        end
    end

endmodule

/* verilog/cache_unit.sv */
// ######################################################################
// write-back data cache unit
// ######################################################################

`timescale 1ns/1ps

module cache_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    req,
    input  cache_pkg::cpu_req_t     cpu_req,
    output logic                    miss,
    output cache_pkg::data_word_t   read_word,
    output logic                    mem_req,
    output logic [31:0]             mem_read_addr,
    input  cache_pkg::block_data_t  mem_read_block,
    output cache_pkg::mem_wb_t      mem_wb,
    input  logic                    mem_miss
);
    import cache_pkg::*;

    cache_set_t [SETS-1:0] sets_q;
    cache_set_t            cur_set;
    cache_set_t            set_next;
    addr_fields_t          req_fields;
    cache_addr_u           fill_addr;
    cache_addr_u           victim_addr;
    block_t                victim;
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  used_way;
    logic                  update;

    // byte lane merge of a cpu write word
    function automatic data_word_t merge_bytes(data_word_t old_word, data_word_t new_word,
                                               logic [3:0] mask);
        data_word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign req_fields = cpu_req.addr.fields;
    assign cur_set    = sets_q[req_fields.index];
    assign victim     = cur_set[victim_way];

    cache_lookup u_lookup (
        .set_ways   (cur_set),
        .tag        (req_fields.tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    assign miss      = req && !hit;
    assign read_word = cur_set[hit_way].data[req_fields.offset];
    assign mem_req   = miss;

    // block aligned addresses for the two memory ports
    always_comb begin
        fill_addr                      = cpu_req.addr;
        fill_addr.fields.offset        = '0;
        fill_addr.fields.byte_sel      = '0;
        victim_addr                    = fill_addr;
        victim_addr.fields.tag         = victim.tag;
        mem_read_addr                  = fill_addr.raw;
    end

    // dirty victim goes out on the write port
    assign mem_wb.we    = mem_req && victim.valid && victim.dirty;
    assign mem_wb.addr  = victim_addr.raw;
    assign mem_wb.block = victim.data;

    // next state of the addressed set
    always_comb begin
        set_next = cur_set;
        used_way = hit ? hit_way : victim_way;
        if (hit) begin
            if (cpu_req.we) begin
                set_next[hit_way].dirty = 1'b1;
                set_next[hit_way].data[req_fields.offset] =
                    merge_bytes(cur_set[hit_way].data[req_fields.offset],
                                cpu_req.write_word, cpu_req.byte_mask);
            end
        end else begin
            // refill where a write miss merges into the fetched block
            set_next[victim_way].tag   = req_fields.tag;
            set_next[victim_way].valid = 1'b1;
            set_next[victim_way].dirty = cpu_req.we;
            set_next[victim_way].data  = mem_read_block;
            if (cpu_req.we) begin
                set_next[victim_way].data[req_fields.offset] =
                    merge_bytes(mem_read_block[req_fields.offset],
                                cpu_req.write_word, cpu_req.byte_mask);
            end
        end
        // used way becomes mru
        for (int w = 0; w < WAYS; w++) begin
            set_next[w].lru = (1'(w) != used_way);
        end
    end

    // hit edge or the edge that completes the memory access
    assign update = req && (hit || !mem_miss);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    sets_q[s][w]     <= '0;
                    sets_q[s][w].lru <= 1'(w);
                end
            end
        end else if (update) begin
            sets_q[req_fields.index] <= set_next;
        end
    end

    a_wb_needs_req: assert property (@(posedge clock) disable iff (!reset)
        mem_wb.we |-> mem_req && (mem_wb.addr != mem_read_addr));

    for (genvar s = 0; s < SETS; s++) begin : g_set_chk
        a_lru_distinct: assert property (@(posedge clock) disable iff (!reset)
            sets_q[s][0].lru != sets_q[s][1].lru);

        a_no_dup_tag: assert property (@(posedge clock) disable iff (!reset)
            !(sets_q[s][0].valid && sets_q[s][1].valid &&
              sets_q[s][0].tag == sets_q[s][1].tag));
    end

endmodule

/* verilog/backing_memory.sv */
// ######################################################################
// backing memory with fixed latency
// ######################################################################

`timescale 1ns/1ps

module backing_memory (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    mem_req,
    input  logic [31:0]             mem_read_addr,
    output cache_pkg::block_data_t  mem_read_block,
    input  cache_pkg::mem_wb_t      mem_wb,
    output logic                    mem_miss
);
    import cache_pkg::*;

    data_word_t              mem_q [MEM_WORDS];
    logic [LAT_BITS-1:0]     lat_count;
    logic [MEM_IDX_BITS-1:0] rd_idx;
    logic [MEM_IDX_BITS-1:0] wr_idx;
    logic                    done;

    // only the low address bits select a word
    assign rd_idx = mem_read_addr[MEM_IDX_BITS+1:2];
    assign wr_idx = mem_wb.addr[MEM_IDX_BITS+1:2];

    // busy from the first cycle of a request
    assign mem_miss = mem_req && (lat_count != LAT_BITS'(MEM_LATENCY));
    assign done     = mem_req && !mem_miss;

    // latency counter, back to zero after completion
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            lat_count <= '0;
        end else if (mem_req && mem_miss) begin
            lat_count <= lat_count + 1'b1;
        end else begin
            lat_count <= '0;
        end
    end

    // block read port, aligned so the word offset is or-ed in
    always_comb begin
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
            mem_read_block[k] = mem_q[rd_idx | MEM_IDX_BITS'(k)];
        end
    end

    // word i holds ~i in the upper half and i in the lower half after reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= {~16'(i), 16'(i)};
            end
        end else if (done && mem_wb.we) begin
            for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
                mem_q[wr_idx | MEM_IDX_BITS'(k)] <= mem_wb.block[k];
            end
        end
    end

    // the cache must keep the fill address while the access runs
    a_addr_stable: assert property (@(posedge clock) disable iff (!reset)
        (mem_req && mem_miss) |=> $stable(mem_read_addr));

endmodule

/* verilog/cache_subsystem.sv */
// ######################################################################
// cache subsystem top
// ######################################################################

`timescale 1ns/1ps

module cache_subsystem (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req,
    input  cache_pkg::cpu_req_t    cpu_req,
    output logic                   miss,
    output cache_pkg::data_word_t  read_word
);
    import cache_pkg::*;

    // cache to memory
    logic        mem_req;
    logic [31:0] mem_read_addr;
    block_data_t mem_read_block;
    mem_wb_t     mem_wb;
    logic        mem_miss;

    cache_unit u_cache (
        .clock          (clock),
        .reset          (reset),
        .req            (req),
        .cpu_req        (cpu_req),
        .miss           (miss),
        .read_word      (read_word),
        .mem_req        (mem_req),
        .mem_read_addr  (mem_read_addr),
        .mem_read_block (mem_read_block),
        .mem_wb         (mem_wb),
        .mem_miss       (mem_miss)
    );

    backing_memory u_memory (
        .clock          (clock),
        .reset          (reset),
        .mem_req        (mem_req),
        .mem_read_addr  (mem_read_addr),
        .mem_read_block (mem_read_block),
        .mem_wb         (mem_wb),
        .mem_miss       (mem_miss)
    );

endmodule

/* verif/cache_model.svh */
// ######################################################################
// cache reference model
// ######################################################################

`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// architectural memory contents, what every read must return
data_word_t          shadow_mem   [MEM_WORDS];
logic [TAG_BITS-1:0] shadow_tag   [SETS][WAYS];
logic                shadow_valid [SETS][WAYS];
logic                shadow_dirty [SETS][WAYS];
logic                shadow_lru   [SETS][WAYS];

// power-up state of memory and cache
function automatic void model_reset();
    for (int i = 0; i < MEM_WORDS; i++) begin
        shadow_mem[i] = {~16'(i), 16'(i)};
    end
    for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
            shadow_tag[s][w]   = '0;
            shadow_valid[s][w] = 1'b0;
            shadow_dirty[s][w] = 1'b0;
            shadow_lru[s][w]   = (w == 1);
        end
    end
endfunction

// way holding the tag, -1 when absent
function automatic int find_way(cache_addr_u a);
    int way;
    way = -1;
    for (int w = 0; w < WAYS; w++) begin
        if (shadow_valid[a.fields.index][w] && shadow_tag[a.fields.index][w] == a.fields.tag) begin
            way = w;
        end
    end
    return way;
endfunction

function automatic logic expected_miss(logic [31:0] addr);
    cache_addr_u a;
    a.raw = addr;
    return find_way(a) < 0;
endfunction

function automatic data_word_t expected_word(logic [31:0] addr);
    return shadow_mem[addr[MEM_IDX_BITS+1:2]];
endfunction

// byte lanes with a mask bit set take the new data
function automatic void apply_write(logic [31:0] addr, logic [3:0] mask, data_word_t data);
    int idx;
    idx = addr[MEM_IDX_BITS+1:2];
    for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
            shadow_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
    end
endfunction

// tag, dirty and lru state after one completed access
function automatic void model_access(logic [31:0] addr, logic we);
    cache_addr_u a;
    int          way;
    int          s;
    a.raw = addr;
    s     = a.fields.index;
    way   = find_way(a);
    if (way < 0) begin
        // refill the lru way; a dirty victim's data already sits in shadow_mem
        way = shadow_lru[s][0] ? 0 : 1;
        shadow_tag[s][way]   = a.fields.tag;
        shadow_valid[s][way] = 1'b1;
        shadow_dirty[s][way] = we;
    end else if (we) begin
        shadow_dirty[s][way] = 1'b1;
    end
    for (int w = 0; w < WAYS; w++) begin
        shadow_lru[s][w] = (w != way);
    end
endfunction

`endif

/* verif/cache_tb.sv */
// ######################################################################
// data cache testbench
// ######################################################################

`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic       clock;
    logic       reset;
    logic       req;
    cpu_req_t   cpu_req;
    logic       miss;
    data_word_t read_word;

    `include "cache_model.svh"

    cache_subsystem dut (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .cpu_req   (cpu_req),
        .miss      (miss),
        .read_word (read_word)
    );

    always #5 clock = ~clock;

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_miss(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: miss expected %b, actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %s: miss cycles expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    // one cpu access, held until miss falls, then checked against the model
    task automatic run_access(input string name, input logic we, input logic [31:0] addr,
                              input logic [3:0] mask, input data_word_t data);
        logic       exp_miss;
        data_word_t exp_word;
        int         cycles;
        exp_miss = expected_miss(addr);
        exp_word = expected_word(addr);
        @(posedge clock);
        #1;
        req                = 1'b1;
        cpu_req.we         = we;
        cpu_req.addr.raw   = addr;
        cpu_req.byte_mask  = mask;
        cpu_req.write_word = data;
        // outputs are combinational, sample mid cycle
        @(negedge clock);
        check_miss(name, exp_miss, miss);
        cycles = 0;
        while (miss) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("miss never cleared during %s", name);
                stop_run();
            end else begin
                @(negedge clock);
                cycles++;
            end
        end
        if (exp_miss) begin
            check_cycles(name, MEM_LATENCY + 1, cycles);
        end
        if (!we) begin
            check_word(name, exp_word, read_word);
        end
        model_access(addr, we);
        if (we) begin
            apply_write(addr, mask, data);
        end
        // the write lands on this edge
        @(posedge clock);
        #1;
        req     = 1'b0;
        cpu_req = '0;
    endtask

    initial begin
        logic [31:0] addr;
        logic [3:0]  mask;
        data_word_t  data;
        logic        we;
        clock   = 1'b0;
        reset   = 1'b0;
        req     = 1'b0;
        cpu_req = '0;
        void'($urandom(81932));
        model_reset();
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;

        // tag 4, set 0
        run_access("cold read miss", 1'b0, 32'h40, 4'h0, '0);
        run_access("read hit after fill", 1'b0, 32'h44, 4'h0, '0);

        for (int i = 0; i < 6; i++) begin
            addr = (i % 2) ? 32'h44 : 32'h40;
            mask = 4'($urandom);
            data = $urandom;
            run_access($sformatf("write hit %0d", i), 1'b1, addr, mask, data);
            run_access($sformatf("read after write %0d", i), 1'b0, addr, 4'h0, '0);
        end

        // tag 5, set 1
        data = $urandom;
        run_access("write miss", 1'b1, 32'h58, 4'b0101, data);
        run_access("write miss merged word", 1'b0, 32'h58, 4'h0, '0);
        run_access("write miss other word", 1'b0, 32'h5c, 4'h0, '0);

        // tags 8, 9 and 10 all in set 0, tag 8 left dirty
        data = $urandom;
        run_access("evict dirty write", 1'b1, 32'h80, 4'hf, data);
        run_access("evict second tag", 1'b0, 32'h90, 4'h0, '0);
        run_access("evict third tag", 1'b0, 32'ha0, 4'h0, '0);
        run_access("refetch written back", 1'b0, 32'h80, 4'h0, '0);

        // 4 tags per set over 2 sets and 2 words
        for (int i = 0; i < 200; i++) begin
            addr = 32'($urandom % 16) << 2;
            we   = 1'($urandom);
            mask = 4'($urandom);
            data = $urandom;
            run_access($sformatf("random op %0d", i), we, addr, mask, data);
        end

        $display("test passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
verilog/cache_pkg.sv
verilog/cache_lookup.sv
verilog/cache_unit.sv
verilog/backing_memory.sv
verilog/cache_subsystem.sv
verif/cache_tb.sv
